//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_chess
FILE_LIST  = tb.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

//--- all_moves.sv
`timescale 1ns/1ns
`include "chess_cfg.svh"

module all_moves (
   input  logic              clk,
   input  logic              reset,
   input  logic              board_valid,
   input  chess_pkg::board_t board_in,
   input  logic              white_to_move_in,
   input  logic [3:0]        castle_mask_in,
   input  logic [3:0]        en_passant_col_in,
   input  logic              clear_moves,
   output logic              moves_ready,
   output logic              white_in_check,
   output logic              black_in_check,
   move_store_if.gen         ms
);

   chess_pkg::gen_state_e state;
   chess_pkg::board_t     board;
   logic                  white_to_move;
   logic [3:0]            castle_mask;
   logic [3:0]            en_passant_col;
   chess_pkg::square_t    sq;
   chess_pkg::square_t    ray_sq;
   chess_pkg::piece_t     sq_piece;
   chess_pkg::piece_t     piece;
   chess_pkg::piece_t     target;
   logic [3:0]            dir;
   logic [3:0]            step;
   logic signed [4:0]     ray_r;
   logic signed [4:0]     ray_c;
   logic                  can_move;
   logic                  atk_start;
   logic                  atk_done;

   always_comb
   begin
      sq_piece = chess_pkg::piece_t'(board[{sq, 2'b00} +: `PIECE_BITS]);
      ray_sq   = {ray_r[2:0], ray_c[2:0]};
      target   = chess_pkg::piece_t'(board[{ray_sq, 2'b00} +: `PIECE_BITS]);
      step     = chess_pkg::slider_step(piece.kind, dir[2:0]);
      can_move = chess_pkg::on_board(ray_r, ray_c) &&
                 (target.kind == chess_pkg::EMPTY || target.black != piece.black);
   end

   always_ff @(posedge clk)
   begin
      ms.wr     <= 1'b0;
      ms.start  <= 1'b0;
      atk_start <= 1'b0;
      if (reset)
      begin
         state       <= chess_pkg::IDLE;
         moves_ready <= 1'b0;
      end
      else
      begin
         case (state)
            chess_pkg::IDLE:
               if (board_valid)
               begin
                  board          <= board_in;
                  white_to_move  <= white_to_move_in;
                  castle_mask    <= castle_mask_in;
                  en_passant_col <= en_passant_col_in;
                  atk_start      <= 1'b1;
                  state          <= chess_pkg::GET_ATTACKS;
               end
            chess_pkg::GET_ATTACKS:
               if (atk_done)
                  state <= chess_pkg::INIT;
            chess_pkg::INIT:
            begin
               sq                <= '0;
               ms.start          <= 1'b1;
               ms.white_to_move  <= ~white_to_move; // Successors have the other side to move
               ms.castle_mask    <= castle_mask;
               ms.en_passant_col <= en_passant_col;
               state             <= chess_pkg::DO_SQUARE;
            end
            chess_pkg::DO_SQUARE:
            begin
               piece <= sq_piece;
               dir   <= '0;
               if (chess_pkg::is_slider(sq_piece.kind) && sq_piece.black != white_to_move)
                  state <= chess_pkg::SLIDER_INIT;
               else
                  state <= chess_pkg::NEXT;
            end
            chess_pkg::SLIDER_INIT:
               if (dir < chess_pkg::dir_count(piece.kind))
               begin
                  ray_r <= $signed({2'b00, sq[5:3]}) + $signed(step[3:2]);
                  ray_c <= $signed({2'b00, sq[2:0]}) + $signed(step[1:0]);
                  state <= chess_pkg::SLIDER;
               end
               else
                  state <= chess_pkg::NEXT;
            chess_pkg::SLIDER:
            begin
               if (can_move)
               begin
                  ms.wr    <= 1'b1;
                  ms.board <= board;
                  ms.board[{sq, 2'b00} +: `PIECE_BITS]     <= '0;
                  ms.board[{ray_sq, 2'b00} +: `PIECE_BITS] <= piece;
                  ray_r    <= ray_r + $signed(step[3:2]);
                  ray_c    <= ray_c + $signed(step[1:0]);
               end
               if (!can_move || target.kind != chess_pkg::EMPTY) // Edge, block or capture
               begin
                  dir   <= dir + 4'd1;
                  state <= chess_pkg::SLIDER_INIT;
               end
            end
            chess_pkg::NEXT:
            begin
               sq    <= sq + 6'd1;
               state <= (sq == 6'd63) ? chess_pkg::DONE : chess_pkg::DO_SQUARE;
            end
            chess_pkg::DONE:
               if (clear_moves)
               begin
                  moves_ready <= 1'b0;
                  state       <= chess_pkg::IDLE;
               end
               else
                  moves_ready <= 1'b1;
         endcase
      end
   end

   board_attack u_attack (
      .clk            (clk),
      .reset          (reset),
      .start          (atk_start),
      .board          (board),
      .white_attacks  (),
      .black_attacks  (),
      .white_in_check (white_in_check),
      .black_in_check (black_in_check),
      .done           (atk_done)
   );

   // Writes only come from walking one of the mover's sliders
   wr_in_slider: assert property (@(posedge clk) disable iff (reset)
      ms.wr |-> $past(state) == chess_pkg::SLIDER && chess_pkg::is_slider(piece.kind) &&
                piece.black != white_to_move);

endmodule

//--- board_attack.sv
`timescale 1ns/1ns
`include "chess_cfg.svh"

module board_attack (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  chess_pkg::board_t    board,
   output logic [`SQUARES-1:0]  white_attacks,
   output logic [`SQUARES-1:0]  black_attacks,
   output logic                 white_in_check,
   output logic                 black_in_check,
   output logic                 done
);

   chess_pkg::attack_state_e state;
   chess_pkg::square_t       sq;
   chess_pkg::square_t       ray_sq;
   chess_pkg::square_t       white_king_sq;
   chess_pkg::square_t       black_king_sq;
   logic                     white_king_found;
   logic                     black_king_found;
   chess_pkg::piece_t        sq_piece;
   chess_pkg::piece_t        piece;        // Slider being walked
   chess_pkg::piece_t        target;
   chess_pkg::piece_kind_e   step_kind;
   logic [3:0]               dir;
   logic [3:0]               next_dir;
   logic [3:0]               ray_step;
   logic [3:0]               next_step;
   logic signed [4:0]        ray_r;
   logic signed [4:0]        ray_c;
   logic                     in_board;
   logic                     last_sq;
   logic [`SQUARES-1:0]      leaper;

   // Pawn, knight and king targets
   function automatic logic [`SQUARES-1:0] leaper_mask(chess_pkg::piece_t p,
                                                      chess_pkg::square_t s);
      logic [`SQUARES-1:0] m;
      logic                hit;
      int                  r;
      int                  c;
      int                  ar;
      int                  ac;
      m = '0;
      for (int dr = -2; dr <= 2; dr++)
      begin
         for (int dc = -2; dc <= 2; dc++)
         begin
            r  = int'(s[5:3]) + dr;
            c  = int'(s[2:0]) + dc;
            ar = (dr < 0) ? -dr : dr;
            ac = (dc < 0) ? -dc : dc;
            case (p.kind)
               chess_pkg::PAWN:   hit = ac == 1 && dr == (p.black ? -1 : 1); // White goes up
               chess_pkg::KNIGHT: hit = ar * ac == 2;
               chess_pkg::KING:   hit = ar <= 1 && ac <= 1 && ar + ac != 0;
               default:           hit = 1'b0;
            endcase
            if (hit && r >= 0 && r <= 7 && c >= 0 && c <= 7)
               m[r * 8 + c] = 1'b1;
         end
      end
      return m;
   endfunction

   always_comb
   begin
      sq_piece  = chess_pkg::piece_t'(board[{sq, 2'b00} +: `PIECE_BITS]);
      ray_sq    = {ray_r[2:0], ray_c[2:0]};
      target    = chess_pkg::piece_t'(board[{ray_sq, 2'b00} +: `PIECE_BITS]);
      in_board  = chess_pkg::on_board(ray_r, ray_c);
      last_sq   = sq == 6'd63;
      next_dir  = (state == chess_pkg::ATK_SQUARE) ? 4'd0 : dir + 4'd1;
      step_kind = (state == chess_pkg::ATK_SQUARE) ? sq_piece.kind : piece.kind;
      ray_step  = chess_pkg::slider_step(piece.kind, dir[2:0]);
      next_step = chess_pkg::slider_step(step_kind, next_dir[2:0]);
      leaper    = leaper_mask(sq_piece, sq);
   end

   always_ff @(posedge clk)
   begin
      done <= 1'b0;
      if (reset)
      begin
         state            <= chess_pkg::ATK_IDLE;
         white_attacks    <= '0;
         black_attacks    <= '0;
         white_in_check   <= 1'b0;
         black_in_check   <= 1'b0;
         white_king_found <= 1'b0;
         black_king_found <= 1'b0;
      end
      else
      begin
         case (state)
            chess_pkg::ATK_IDLE:
               if (start)
               begin
                  white_attacks    <= '0;
                  black_attacks    <= '0;
                  white_in_check   <= 1'b0;
                  black_in_check   <= 1'b0;
                  white_king_found <= 1'b0;
                  black_king_found <= 1'b0;
                  sq               <= '0;
                  state            <= chess_pkg::ATK_SQUARE;
               end
            chess_pkg::ATK_SQUARE:
            begin
               piece <= sq_piece;
               if (sq_piece.kind == chess_pkg::KING && sq_piece.black)
               begin
                  black_king_sq    <= sq;
                  black_king_found <= 1'b1;
               end
               if (sq_piece.kind == chess_pkg::KING && !sq_piece.black)
               begin
                  white_king_sq    <= sq;
                  white_king_found <= 1'b1;
               end
               if (chess_pkg::is_slider(sq_piece.kind))
               begin
                  dir   <= '0;
                  ray_r <= $signed({2'b00, sq[5:3]}) + $signed(next_step[3:2]);
                  ray_c <= $signed({2'b00, sq[2:0]}) + $signed(next_step[1:0]);
                  state <= chess_pkg::ATK_RAY;
               end
               else
               begin
                  if (sq_piece.black)
                     black_attacks <= black_attacks | leaper;
                  else
                     white_attacks <= white_attacks | leaper; // Empty square adds nothing
                  sq    <= sq + 6'd1;
                  state <= last_sq ? chess_pkg::ATK_DONE : chess_pkg::ATK_SQUARE;
               end
            end
            chess_pkg::ATK_RAY:
            begin
               if (in_board && piece.black)
                  black_attacks[ray_sq] <= 1'b1;
               if (in_board && !piece.black)
                  white_attacks[ray_sq] <= 1'b1;
               if (in_board && target.kind == chess_pkg::EMPTY)
               begin
                  ray_r <= ray_r + $signed(ray_step[3:2]);
                  ray_c <= ray_c + $signed(ray_step[1:0]);
               end
               else if (next_dir < chess_pkg::dir_count(piece.kind))
               begin
                  dir   <= next_dir;
                  ray_r <= $signed({2'b00, sq[5:3]}) + $signed(next_step[3:2]);
                  ray_c <= $signed({2'b00, sq[2:0]}) + $signed(next_step[1:0]);
               end
               else
               begin
                  sq    <= sq + 6'd1;
                  state <= last_sq ? chess_pkg::ATK_DONE : chess_pkg::ATK_SQUARE;
               end
            end
            chess_pkg::ATK_DONE:
            begin
               white_in_check <= white_king_found && black_attacks[white_king_sq];
               black_in_check <= black_king_found && white_attacks[black_king_sq];
               done           <= 1'b1;
               state          <= chess_pkg::ATK_IDLE;
            end
         endcase
      end
   end

   done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done);

endmodule

//--- chess_cfg.svh
`ifndef CHESS_CFG_SVH
`define CHESS_CFG_SVH

// Board geometry
`define PIECE_BITS 4
`define SQUARES 64
`define BOARD_BITS 256

// Successor position store
`define MAX_POSITIONS 256
`define POS_INDEX_BITS 8

`endif

//--- chess_pkg.sv
`include "chess_cfg.svh"

package chess_pkg;

   typedef enum logic [2:0] {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_kind_e;

   // One square, black bit on top
   typedef struct packed {
      logic        black;
      piece_kind_e kind;
   } piece_t;

   typedef logic [`BOARD_BITS-1:0] board_t; // Square row*8+col at bit 4*index
   typedef logic [5:0] square_t;            // {row, col}
   typedef logic [`POS_INDEX_BITS-1:0] pos_index_t;

   typedef enum logic [2:0] {
      IDLE,
      GET_ATTACKS,
      INIT,
      DO_SQUARE,
      SLIDER_INIT,
      SLIDER,
      NEXT,
      DONE
   } gen_state_e;

   typedef enum logic [1:0] {
      ATK_IDLE,
      ATK_SQUARE,
      ATK_RAY,
      ATK_DONE
   } attack_state_e;

   function automatic logic is_slider(piece_kind_e kind);
      return kind inside {BISHOP, ROOK, QUEEN};
   endfunction

   function automatic logic [3:0] dir_count(piece_kind_e kind);
      return (kind == QUEEN) ? 4'd8 : 4'd4;
   endfunction

   // Ray direction as {drow, dcol}, each 2-bit two's complement
   function automatic logic [3:0] slider_step(piece_kind_e kind, logic [2:0] dir);
      logic [3:0] step;
      case (kind)
         ROOK:
            case (dir[1:0])
               2'd0:    step = 4'b00_01;
               2'd1:    step = 4'b00_11;
               2'd2:    step = 4'b01_00;
               default: step = 4'b11_00;
            endcase
         BISHOP:
            case (dir[1:0])
               2'd0:    step = 4'b01_01;
               2'd1:    step = 4'b01_11;
               2'd2:    step = 4'b11_01;
               default: step = 4'b11_11;
            endcase
         default: // Queen, row offset major
            case (dir)
               3'd0:    step = 4'b11_11;
               3'd1:    step = 4'b11_00;
               3'd2:    step = 4'b11_01;
               3'd3:    step = 4'b00_11;
               3'd4:    step = 4'b00_01;
               3'd5:    step = 4'b01_11;
               3'd6:    step = 4'b01_00;
               default: step = 4'b01_01;
            endcase
      endcase
      return step;
   endfunction

   function automatic logic on_board(logic signed [4:0] row, logic signed [4:0] col);
      return row >= 0 && row <= 7 && col >= 0 && col <= 7;
   endfunction

endpackage

//--- chess_top.sv
`timescale 1ns/1ns

module chess_top (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  board_valid,
   input  chess_pkg::board_t     board_in,
   input  logic                  white_to_move_in,
   input  logic [3:0]            castle_mask_in,
   input  logic [3:0]            en_passant_col_in,
   input  chess_pkg::pos_index_t move_index,
   input  logic                  clear_moves,
   output logic                  moves_ready,
   output chess_pkg::pos_index_t move_count,
   output chess_pkg::board_t     board_out,
   output logic                  white_to_move_out,
   output logic [3:0]            castle_mask_out,
   output logic [3:0]            en_passant_col_out,
   output logic                  white_in_check,
   output logic                  black_in_check
);

   move_store_if ms_if ();

   all_moves u_gen (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .board_in          (board_in),
      .white_to_move_in  (white_to_move_in),
      .castle_mask_in    (castle_mask_in),
      .en_passant_col_in (en_passant_col_in),
      .clear_moves       (clear_moves),
      .moves_ready       (moves_ready),
      .white_in_check    (white_in_check),
      .black_in_check    (black_in_check),
      .ms                (ms_if.gen)
   );

   move_store u_store (
      .clk                (clk),
      .reset              (reset),
      .st                 (ms_if.store),
      .move_index         (move_index),
      .move_count         (move_count),
      .board_out          (board_out),
      .white_to_move_out  (white_to_move_out),
      .castle_mask_out    (castle_mask_out),
      .en_passant_col_out (en_passant_col_out)
   );

endmodule

//--- move_store.sv
`timescale 1ns/1ns
`include "chess_cfg.svh"

module move_store (
   input  logic                  clk,
   input  logic                  reset,
   move_store_if.store           st,
   input  chess_pkg::pos_index_t move_index,
   output chess_pkg::pos_index_t move_count,
   output chess_pkg::board_t     board_out,
   output logic                  white_to_move_out,
   output logic [3:0]            castle_mask_out,
   output logic [3:0]            en_passant_col_out
);

   localparam int RAM_W = `BOARD_BITS + 9; // Board, side, castle, en passant

   logic [RAM_W-1:0]      ram [`MAX_POSITIONS];
   logic [RAM_W-1:0]      rd_data;
   chess_pkg::pos_index_t wr_ptr;
   logic                  full;
   logic                  ram_we;

   assign ram_we = st.wr && !full;

   always_ff @(posedge clk)
   begin
      rd_data <= ram[move_index];
      if (ram_we)
         ram[wr_ptr] <= {st.en_passant_col, st.castle_mask, st.white_to_move, st.board};
   end

   always_ff @(posedge clk)
   begin
      if (reset || st.start)
      begin
         wr_ptr <= '0;
         full   <= 1'b0;
      end
      else if (ram_we)
      begin
         if (wr_ptr == '1)
            full <= 1'b1; // Count stays at 255
         else
            wr_ptr <= wr_ptr + 1'b1;
      end
   end

   assign move_count = wr_ptr;
   assign {en_passant_col_out, castle_mask_out, white_to_move_out, board_out} = rd_data;

   full_holds: assert property (@(posedge clk) disable iff (reset)
      full && !st.start |=> full && $stable(wr_ptr));

endmodule

//--- move_store_if.sv
`timescale 1ns/1ns

interface move_store_if;

   logic               start;          // Clears write pointer
   logic               wr;             // One per successor position
   chess_pkg::board_t  board;
   logic               white_to_move;
   logic [3:0]         castle_mask;
   logic [3:0]         en_passant_col;

   modport gen (
      output start,
      output wr,
      output board,
      output white_to_move,
      output castle_mask,
      output en_passant_col
   );

   modport store (
      input start,
      input wr,
      input board,
      input white_to_move,
      input castle_mask,
      input en_passant_col
   );

endinterface

//--- tb.f
+incdir+.
chess_pkg.sv
move_store_if.sv
board_attack.sv
move_store.sv
all_moves.sv
chess_top.sv
tb_chess.sv

//--- tb_chess_cases.svh
`ifndef TB_CHESS_CASES_SVH
`define TB_CHESS_CASES_SVH

// Slider and knight offsets as (row, col), in move order
localparam int ROOK_DR[4]   = '{0, 0, 1, -1};
localparam int ROOK_DC[4]   = '{1, -1, 0, 0};
localparam int BISHOP_DR[4] = '{1, 1, -1, -1};
localparam int BISHOP_DC[4] = '{1, -1, 1, -1};
localparam int QUEEN_DR[8]  = '{-1, -1, -1, 0, 0, 1, 1, 1};
localparam int QUEEN_DC[8]  = '{-1, 0, 1, -1, 1, -1, 0, 1};
localparam int KNIGHT_DR[8] = '{-2, -2, -1, -1, 1, 1, 2, 2};
localparam int KNIGHT_DC[8] = '{-1, 1, -2, 2, -2, 2, -1, 1};

// Stimulus table, count of -1 means only the model decides
string             case_name[$];
chess_pkg::board_t case_board[$];
logic              case_wtm[$];
logic [3:0]        case_castle[$];
logic [3:0]        case_ep[$];
int                case_count[$];

// Model results for the current case
chess_pkg::board_t exp_boards[$];
logic              exp_wchk;
logic              exp_bchk;

logic [15:0] lfsr = 16'd29;

function automatic logic next_bit();
   logic b;
   b    = lfsr[0];
   lfsr = lfsr >> 1;
   if (b)
      lfsr = lfsr ^ 16'hB400; // Galois taps 16,14,13,11
   return b;
endfunction

function automatic int take_bits(input int n);
   int v;
   v = 0;
   for (int i = 0; i < n; i++)
      v = (v << 1) | int'(next_bit());
   return v;
endfunction

function automatic chess_pkg::board_t put_piece(input chess_pkg::board_t b, input int sq,
                                                input logic [3:0] p);
   chess_pkg::board_t nb;
   nb = b;
   nb[4 * sq +: 4] = p;
   return nb;
endfunction

function automatic logic [`SQUARES-1:0] mark(input logic [`SQUARES-1:0] hits,
                                            input int r, input int c);
   logic [`SQUARES-1:0] m;
   m = hits;
   if (r >= 0 && r < 8 && c >= 0 && c < 8)
      m[r * 8 + c] = 1'b1;
   return m;
endfunction

task automatic add_case(input string name, input chess_pkg::board_t b, input logic wtm,
                        input logic [3:0] cm, input logic [3:0] ep, input int count);
   case_name.push_back(name);
   case_board.push_back(b);
   case_wtm.push_back(wtm);
   case_castle.push_back(cm);
   case_ep.push_back(ep);
   case_count.push_back(count);
endtask

task automatic random_board(input int n);
   chess_pkg::board_t b;
   int                kind;
   int                color;
   int                sq;
   logic              has_wk;
   logic              has_bk;
   logic              wtm;
   logic [3:0]        cm;
   logic [3:0]        ep;
   b      = '0;
   has_wk = 1'b0;
   has_bk = 1'b0;
   for (int i = 0; i < 16; i++)
   begin
      kind  = take_bits(3);
      color = take_bits(1);
      sq    = take_bits(6);
      // Skip empty and unused kinds, taken squares and a second king
      if (kind != 0 && kind != 7 && b[4 * sq +: 4] == 4'h0 &&
          !(kind == 6 && (color == 1 ? has_bk : has_wk)))
      begin
         if (kind == 6 && color == 1)
            has_bk = 1'b1;
         if (kind == 6 && color == 0)
            has_wk = 1'b1;
         b = put_piece(b, sq, {color[0], kind[2:0]});
      end
   end
   wtm = 1'(take_bits(1));
   cm  = 4'(take_bits(4));
   ep  = 4'(take_bits(4));
   add_case($sformatf("random %0d", n), b, wtm, cm, ep, -1);
endtask

task automatic build_table();
   chess_pkg::board_t b;
   add_case("lone rook", put_piece('0, 27, 4'h4), 1'b1, 4'hF, 4'h0, 14);
   add_case("lone queen", put_piece('0, 0, 4'h5), 1'b1, 4'h3, 4'h5, 21);
   b = put_piece('0, 0, 4'h4);
   b = put_piece(b, 3, 4'h1);   // Own pawn blocks
   b = put_piece(b, 16, 4'hA);  // Black knight taken
   b = put_piece(b, 7, 4'h6);
   b = put_piece(b, 36, 4'hD);
   b = put_piece(b, 63, 4'hB);
   add_case("block and capture", b, 1'b1, 4'h9, 4'h2, 4);
   b = put_piece('0, 63, 4'hB);
   b = put_piece(b, 56, 4'hC);
   b = put_piece(b, 27, 4'h4);
   b = put_piece(b, 20, 4'h5);
   add_case("black to move", b, 1'b0, 4'h0, 4'hF, 17);
   b = put_piece('0, 4, 4'h6);
   b = put_piece(b, 11, 4'h9);  // Pawn on white king
   b = put_piece(b, 60, 4'hE);
   b = put_piece(b, 45, 4'h2);  // Knight on black king
   add_case("pawn and knight check", b, 1'b1, 4'h6, 4'h1, 0);
   b = put_piece('0, 4, 4'h6);
   b = put_piece(b, 60, 4'hC);
   b = put_piece(b, 63, 4'hE);
   add_case("open file check", b, 1'b0, 4'hC, 4'h3, 13);
   b = put_piece(b, 12, 4'h1);
   add_case("blocked file", b, 1'b0, 4'hC, 4'h3, 12);
   for (int n = 0; n < 6; n++)
      random_board(n);
endtask

// Ordered successor list and check flags for one position
task automatic run_model(input chess_pkg::board_t b, input logic wtm);
   logic [3:0]          p;
   logic [3:0]          t;
   logic [`SQUARES-1:0] hits;
   logic [`SQUARES-1:0] atk_w;
   logic [`SQUARES-1:0] atk_b;
   chess_pkg::board_t   nb;
   logic                black;
   logic                stop;
   int                  kind;
   int                  nd;
   int                  dr;
   int                  dc;
   int                  r;
   int                  c;
   int                  wk;
   int                  bk;
   exp_boards.delete();
   atk_w = '0;
   atk_b = '0;
   wk    = -1;
   bk    = -1;
   for (int s = 0; s < 64; s++)
   begin
      p     = b[4 * s +: 4];
      kind  = int'(p[2:0]);
      black = p[3];
      hits  = '0;
      if (kind == 6 && black)
         bk = s;
      if (kind == 6 && !black)
         wk = s;
      if (kind == 1)
      begin
         hits = mark(hits, s / 8 + (black ? -1 : 1), s % 8 - 1);
         hits = mark(hits, s / 8 + (black ? -1 : 1), s % 8 + 1);
      end
      for (int k = 0; k < 8; k++)
      begin
         if (kind == 2)
            hits = mark(hits, s / 8 + KNIGHT_DR[k], s % 8 + KNIGHT_DC[k]);
         if (kind == 6)
            hits = mark(hits, s / 8 + QUEEN_DR[k], s % 8 + QUEEN_DC[k]);
      end
      nd = (kind == 5) ? 8 : (kind == 3 || kind == 4) ? 4 : 0;
      for (int d = 0; d < nd; d++)
      begin
         dr = (kind == 5) ? QUEEN_DR[d] : (kind == 4) ? ROOK_DR[d % 4] : BISHOP_DR[d % 4];
         dc = (kind == 5) ? QUEEN_DC[d] : (kind == 4) ? ROOK_DC[d % 4] : BISHOP_DC[d % 4];
         r    = s / 8 + dr;
         c    = s % 8 + dc;
         stop = 1'b0;
         while (!stop && r >= 0 && r < 8 && c >= 0 && c < 8)
         begin
            t = b[4 * (r * 8 + c) +: 4];
            hits[r * 8 + c] = 1'b1;
            if (t != 4'h0 && t[3] == black)
               stop = 1'b1; // Own piece
            else
            begin
               if (black == !wtm)
               begin
                  nb = b;
                  nb[4 * s +: 4]           = 4'h0;
                  nb[4 * (r * 8 + c) +: 4] = p;
                  exp_boards.push_back(nb);
               end
               stop = t != 4'h0;
               r    = r + dr;
               c    = c + dc;
            end
         end
      end
      if (black)
         atk_b = atk_b | hits;
      else
         atk_w = atk_w | hits;
   end
   exp_wchk = wk >= 0 && atk_b[wk];
   exp_bchk = bk >= 0 && atk_w[bk];
endtask

`endif

//--- tb_chess.sv
`timescale 1ns/1ns
`include "chess_cfg.svh"

module tb_chess;

   localparam int TIMEOUT_CYCLES = 20000;

   logic                  clk;
   logic                  reset;
   logic                  board_valid;
   chess_pkg::board_t     board_in;
   logic                  white_to_move_in;
   logic [3:0]            castle_mask_in;
   logic [3:0]            en_passant_col_in;
   chess_pkg::pos_index_t move_index;
   logic                  clear_moves;
   logic                  moves_ready;
   chess_pkg::pos_index_t move_count;
   chess_pkg::board_t     board_out;
   logic                  white_to_move_out;
   logic [3:0]            castle_mask_out;
   logic [3:0]            en_passant_col_out;
   logic                  white_in_check;
   logic                  black_in_check;

   `include "tb_chess_cases.svh"

   chess_top u_dut (
      .clk                (clk),
      .reset              (reset),
      .board_valid        (board_valid),
      .board_in           (board_in),
      .white_to_move_in   (white_to_move_in),
      .castle_mask_in     (castle_mask_in),
      .en_passant_col_in  (en_passant_col_in),
      .move_index         (move_index),
      .clear_moves        (clear_moves),
      .moves_ready        (moves_ready),
      .move_count         (move_count),
      .board_out          (board_out),
      .white_to_move_out  (white_to_move_out),
      .castle_mask_out    (castle_mask_out),
      .en_passant_col_out (en_passant_col_out),
      .white_in_check     (white_in_check),
      .black_in_check     (black_in_check)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check(input string name, input logic [255:0] expected,
                        input logic [255:0] actual);
      if (expected !== actual)
      begin
         $display("mismatch %s expected %0h actual %0h", name, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic wait_ready(input string name);
      int cycles;
      cycles = 0;
      while (moves_ready !== 1'b1 && cycles < TIMEOUT_CYCLES)
      begin
         @(negedge clk);
         cycles++;
      end
      if (moves_ready !== 1'b1)
      begin
         $display("timeout: moves_ready never rose for %s", name);
         $display("TESTS FAILED");
         $fatal(1, "generator stalled");
      end
   endtask

   task automatic run_case(input int i);
      string name;
      int    n;
      int    reads;
      name = case_name[i];
      run_model(case_board[i], case_wtm[i]);
      n = exp_boards.size();
      if (case_count[i] >= 0)
         check({name, " model count"}, 256'(case_count[i]), 256'(n));
      board_in          = case_board[i];
      white_to_move_in  = case_wtm[i];
      castle_mask_in    = case_castle[i];
      en_passant_col_in = case_ep[i];
      board_valid       = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      @(negedge clk);
      // Second board while the scan runs, dropped by the DUT
      board_in         = ~case_board[i];
      white_to_move_in = ~case_wtm[i];
      board_valid      = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      wait_ready(name);
      check({name, " count"}, 256'((n > 255) ? 255 : n), 256'(move_count));
      check({name, " white check"}, 256'(exp_wchk), 256'(white_in_check));
      check({name, " black check"}, 256'(exp_bchk), 256'(black_in_check));
      reads = (n > 256) ? 256 : n;
      for (int k = 0; k < reads; k++)
      begin
         move_index = 8'(k);
         @(negedge clk); // Registered read port
         check($sformatf("%s move %0d board", name, k), exp_boards[k], board_out);
         check($sformatf("%s move %0d side", name, k), 256'(!case_wtm[i]),
               256'(white_to_move_out));
         check($sformatf("%s move %0d castle", name, k), 256'(case_castle[i]),
               256'(castle_mask_out));
         check($sformatf("%s move %0d en passant", name, k), 256'(case_ep[i]),
               256'(en_passant_col_out));
      end
      clear_moves = 1'b1;
      @(negedge clk);
      clear_moves = 1'b0;
      @(negedge clk);
      check({name, " cleared"}, 256'(0), 256'(moves_ready));
   endtask

   initial
   begin
      reset             = 1'b1;
      board_valid       = 1'b0;
      board_in          = '0;
      white_to_move_in  = 1'b1;
      castle_mask_in    = 4'h0;
      en_passant_col_in = 4'h0;
      move_index        = '0;
      clear_moves       = 1'b0;
      build_table();
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check("reset moves_ready", 256'(0), 256'(moves_ready));
      check("reset white check", 256'(0), 256'(white_in_check));
      check("reset black check", 256'(0), 256'(black_in_check));
      check("reset move_count", 256'(0), 256'(move_count));
      for (int i = 0; i < case_name.size(); i++)
         run_case(i);
      $display("TESTS PASSED");
      $finish;
   end

endmodule
